//--- design/core_pkg.sv
// Core package
// Widths, RV32I encodings, operation enums and the payload
// structs handed from decode to execute to result

package core_pkg;

    ////////////////////////////////////////
    // Widths and base types
    ////////////////////////////////////////
    localparam int xlen       = 32;  // Word width
    localparam int reg_addr_w = 5;   // Register index width
    localparam int num_regs   = 32;  // Integer register count

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////
    // Major opcodes
    localparam logic [6:0] op_alsi  = 7'b0010011;  // Reg-imm ALU
    localparam logic [6:0] op_als   = 7'b0110011;  // Reg-reg ALU
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_br    = 7'b1100011;  // Conditional branches
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;

    // ALU funct3, shared by reg-imm and reg-reg forms
    localparam logic [2:0] f3_add  = 3'b000;  // ADD/SUB, also JALR
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // SRL/SRA
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // funct7 variants
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // SUB, SRA, SRAI

    ////////////////////////////////////////
    // Operation selects
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_nop, alu_add, alu_sub, alu_sll, alu_srl,
        alu_sra, alu_xor, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_nop, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
    } cmp_op_e;

    typedef enum logic [1:0] {
        out_alu,   // ALU result
        out_cmp,   // Zero-extended compare bit
        out_link   // pc + 4 or U immediate
    } out_sel_e;

    // Decode to execute
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      we;         // Already cleared for x0
        alu_op_e   alu_op;
        word_t     alu_in_0;
        word_t     alu_in_1;
        cmp_op_e   cmp_op;
        word_t     cmp_in_0;
        word_t     cmp_in_1;
        out_sel_e  out_sel;
        word_t     link_data;
        logic      is_branch;
        logic      is_jump;
        logic      is_jalr;    // Target bit 0 forced low
        logic      illegal;
    } dec_ctrl_t;

    // Execute to result
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      we;
        word_t     data;
        logic      redirect;   // Taken branch or jump
        word_t     target;
        logic      illegal;
    } ex_result_t;

endpackage

//--- design/rv_decoder.sv
// RV32I decode stage
// Field split, immediates, control decode with illegal detection,
// operand forwarding and the decode pipeline register

`timescale 1ns/1ps

module rv_decoder import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       insn_valid,  // One strobe per instruction
    input  word_t      insn,
    input  word_t      pc,
    input  word_t      rs1_data,    // Register file, combinational
    input  word_t      rs2_data,
    input  ex_result_t ex_now,      // One slot older
    input  ex_result_t ex_reg,      // Two slots older
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output dec_ctrl_t  dec
);

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       f7_base;
    logic       f7_alt;

    assign opcode   = insn[6:0];
    assign rd       = insn[11:7];
    assign funct3   = insn[14:12];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];
    assign funct7   = insn[31:25];
    assign f7_base  = (funct7 == funct7_base);
    assign f7_alt   = (funct7 == funct7_alt);

    // Immediates
    word_t imm_i, imm_sh, imm_u, imm_b, imm_j;

    assign imm_i  = {{20{insn[31]}}, insn[31:20]};
    assign imm_sh = {27'b0, insn[24:20]};  // Shift amount only
    assign imm_u  = {insn[31:12], 12'b0};
    assign imm_b  = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j  = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

    ////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////
    // Newest matching writer wins, else register file
    function automatic word_t fwd_sel(reg_addr_t addr, word_t rf_val);
        if (ex_now.valid && ex_now.we && ex_now.rd == addr)
            return ex_now.data;
        else if (ex_reg.valid && ex_reg.we && ex_reg.rd == addr)
            return ex_reg.data;
        return rf_val;
    endfunction

    word_t rs1_val, rs2_val;

    always_comb begin
        rs1_val = fwd_sel(rs1_addr, rs1_data);
        rs2_val = fwd_sel(rs2_addr, rs2_data);
    end

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////
    dec_ctrl_t nxt;

    always_comb begin
        nxt           = '0;
        nxt.valid     = insn_valid;
        nxt.rd        = rd;
        nxt.alu_op    = alu_nop;
        nxt.alu_in_0  = rs1_val;
        nxt.alu_in_1  = rs2_val;
        nxt.cmp_op    = cmp_nop;
        nxt.cmp_in_0  = rs1_val;
        nxt.cmp_in_1  = rs2_val;
        nxt.out_sel   = out_alu;
        nxt.link_data = pc + 32'd4;  // Return address

        if (insn_valid) begin
            case (opcode)
                op_alsi: begin
                    nxt.we       = 1'b1;
                    nxt.alu_in_1 = imm_i;
                    nxt.cmp_in_1 = imm_i;
                    case (funct3)
                        f3_add:  nxt.alu_op = alu_add;
                        f3_sll: begin
                            nxt.alu_op   = alu_sll;
                            nxt.alu_in_1 = imm_sh;
                            nxt.illegal  = !f7_base;
                        end
                        f3_slt: begin
                            nxt.cmp_op  = cmp_lt;
                            nxt.out_sel = out_cmp;
                        end
                        f3_sltu: begin
                            nxt.cmp_op  = cmp_ltu;
                            nxt.out_sel = out_cmp;
                        end
                        f3_xor:  nxt.alu_op = alu_xor;
                        f3_sr: begin
                            nxt.alu_op   = f7_alt ? alu_sra : alu_srl;
                            nxt.alu_in_1 = imm_sh;
                            nxt.illegal  = !(f7_base || f7_alt);
                        end
                        f3_or:   nxt.alu_op = alu_or;
                        f3_and:  nxt.alu_op = alu_and;
                    endcase
                end
                op_als: begin
                    nxt.we = 1'b1;
                    case (funct3)
                        f3_add:  nxt.alu_op = f7_alt ? alu_sub : alu_add;
                        f3_sll:  nxt.alu_op = alu_sll;
                        f3_slt: begin
                            nxt.cmp_op  = cmp_lt;
                            nxt.out_sel = out_cmp;
                        end
                        f3_sltu: begin
                            nxt.cmp_op  = cmp_ltu;
                            nxt.out_sel = out_cmp;
                        end
                        f3_xor:  nxt.alu_op = alu_xor;
                        f3_sr:   nxt.alu_op = f7_alt ? alu_sra : alu_srl;
                        f3_or:   nxt.alu_op = alu_or;
                        f3_and:  nxt.alu_op = alu_and;
                    endcase
                    // Alt funct7 only legal on ADD/SUB and SRL/SRA
                    nxt.illegal = !(f7_base ||
                                    (f7_alt && (funct3 == f3_add || funct3 == f3_sr)));
                end
                op_lui: begin
                    nxt.we        = 1'b1;
                    nxt.out_sel   = out_link;
                    nxt.link_data = imm_u;       // Passed straight through
                end
                op_auipc: begin
                    nxt.we       = 1'b1;
                    nxt.alu_op   = alu_add;
                    nxt.alu_in_0 = pc;
                    nxt.alu_in_1 = imm_u;
                end
                op_br: begin
                    nxt.is_branch = 1'b1;
                    nxt.alu_op    = alu_add;     // Target pc + B imm
                    nxt.alu_in_0  = pc;
                    nxt.alu_in_1  = imm_b;
                    case (funct3)
                        f3_beq:  nxt.cmp_op = cmp_eq;
                        f3_bne:  nxt.cmp_op = cmp_ne;
                        f3_blt:  nxt.cmp_op = cmp_lt;
                        f3_bge:  nxt.cmp_op = cmp_ge;
                        f3_bltu: nxt.cmp_op = cmp_ltu;
                        f3_bgeu: nxt.cmp_op = cmp_geu;
                        default: nxt.illegal = 1'b1;
                    endcase
                end
                op_jal: begin
                    nxt.we       = 1'b1;
                    nxt.is_jump  = 1'b1;
                    nxt.out_sel  = out_link;
                    nxt.alu_op   = alu_add;
                    nxt.alu_in_0 = pc;
                    nxt.alu_in_1 = imm_j;
                end
                op_jalr: begin
                    nxt.we       = 1'b1;
                    nxt.is_jump  = 1'b1;
                    nxt.is_jalr  = 1'b1;
                    nxt.out_sel  = out_link;
                    nxt.alu_op   = alu_add;      // rs1 + I imm
                    nxt.alu_in_1 = imm_i;
                    nxt.illegal  = (funct3 != f3_add);
                end
                default: nxt.illegal = 1'b1;   // Unknown opcode
            endcase
        end

        // Illegal kills all side effects
        if (nxt.illegal) begin
            nxt.we        = 1'b0;
            nxt.is_branch = 1'b0;
            nxt.is_jump   = 1'b0;
        end
        if (rd == '0)
            nxt.we = 1'b0;                     // x0 never written
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dec <= '0;
        else
            dec <= nxt;
    end

endmodule

//--- design/alu_execute.sv
// Execute stage
// ALU, signed and unsigned comparator, result select and
// redirect target, followed by the execute pipeline register

`timescale 1ns/1ps

module alu_execute import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  dec_ctrl_t  dec,
    output ex_result_t ex_now,   // Same cycle, feeds forwarding
    output ex_result_t ex_reg    // Registered, to result stage
);

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    word_t                    alu_res;
    logic [$clog2(xlen)-1:0]  shamt;

    assign shamt = dec.alu_in_1[$clog2(xlen)-1:0];  // Low bits only

    always_comb begin
        case (dec.alu_op)
            alu_add: alu_res = dec.alu_in_0 + dec.alu_in_1;
            alu_sub: alu_res = dec.alu_in_0 - dec.alu_in_1;
            alu_sll: alu_res = dec.alu_in_0 << shamt;
            alu_srl: alu_res = dec.alu_in_0 >> shamt;
            alu_sra: alu_res = word_t'($signed(dec.alu_in_0) >>> shamt);
            alu_xor: alu_res = dec.alu_in_0 ^ dec.alu_in_1;
            alu_or:  alu_res = dec.alu_in_0 | dec.alu_in_1;
            alu_and: alu_res = dec.alu_in_0 & dec.alu_in_1;
            default: alu_res = '0;          // NOP
        endcase
    end

    ////////////////////////////////////////
    // Comparator
    ////////////////////////////////////////
    logic cmp_res;
    logic lt_s;
    logic lt_u;
    logic eq;

    assign eq   = (dec.cmp_in_0 == dec.cmp_in_1);
    assign lt_s = ($signed(dec.cmp_in_0) < $signed(dec.cmp_in_1));
    assign lt_u = (dec.cmp_in_0 < dec.cmp_in_1);

    always_comb begin
        case (dec.cmp_op)
            cmp_eq:  cmp_res = eq;
            cmp_ne:  cmp_res = !eq;
            cmp_lt:  cmp_res = lt_s;
            cmp_ge:  cmp_res = !lt_s;
            cmp_ltu: cmp_res = lt_u;
            cmp_geu: cmp_res = !lt_u;
            default: cmp_res = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Result and redirect
    ////////////////////////////////////////
    always_comb begin
        ex_now.valid   = dec.valid;
        ex_now.rd      = dec.rd;
        ex_now.we      = dec.we;
        ex_now.illegal = dec.illegal;

        // Writeback value
        case (dec.out_sel)
            out_cmp:  ex_now.data = {{(xlen-1){1'b0}}, cmp_res};
            out_link: ex_now.data = dec.link_data;
            default:  ex_now.data = alu_res;
        endcase

        // Jumps always taken, branches on compare
        ex_now.redirect = dec.is_jump || (dec.is_branch && cmp_res);

        // JALR drops bit 0 of rs1 + imm
        if (dec.is_jalr)
            ex_now.target = {alu_res[xlen-1:1], 1'b0};
        else
            ex_now.target = alu_res;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_reg <= '0;
        else
            ex_reg <= ex_now;
    end

endmodule

//--- design/gpr_writeback.sv
// Result stage
// 32-entry integer register file with two async read ports,
// write on valid result, and the registered retire outputs

`timescale 1ns/1ps

module gpr_writeback import core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ex_result_t ex_reg,
    input  reg_addr_t  rs1_addr,
    input  reg_addr_t  rs2_addr,
    output word_t      rs1_data,
    output word_t      rs2_data,
    output logic       retire_valid,
    output logic       retire_we,
    output logic       retire_redirect,
    output logic       retire_illegal,
    output reg_addr_t  retire_rd,
    output word_t      retire_data,
    output word_t      retire_target
);

    word_t regs [num_regs];

    // Write port, decoder has already masked x0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (ex_reg.valid && ex_reg.we) begin
            regs[ex_reg.rd] <= ex_reg.data;
        end
    end

    assign rs1_data = regs[rs1_addr];  // Async read
    assign rs2_data = regs[rs2_addr];

    ////////////////////////////////////////
    // Retire outputs
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid    <= 1'b0;
            retire_we       <= 1'b0;
            retire_redirect <= 1'b0;
            retire_illegal  <= 1'b0;
        end else begin
            retire_valid    <= ex_reg.valid;
            retire_we       <= ex_reg.valid && ex_reg.we;
            retire_redirect <= ex_reg.valid && ex_reg.redirect;
            retire_illegal  <= ex_reg.valid && ex_reg.illegal;
        end
    end

    // Payload alongside the flags
    always_ff @(posedge clk) begin
        retire_rd     <= ex_reg.rd;
        retire_data   <= ex_reg.data;
        retire_target <= ex_reg.target;
    end

endmodule

//--- design/mini_core.sv
// Mini core top
// Decode, execute and result stages of the RV32I integer datapath

`timescale 1ns/1ps

module mini_core import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      insn_valid,
    input  word_t     insn,
    input  word_t     pc,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output logic      retire_we,
    output word_t     retire_data,
    output logic      retire_redirect,
    output word_t     retire_target,
    output logic      retire_illegal
);

    reg_addr_t  rs1_addr, rs2_addr;   // Decode to register file
    word_t      rs1_data, rs2_data;
    dec_ctrl_t  dec;                  // Decode to execute
    ex_result_t ex_now;               // Forwarding, one slot older
    ex_result_t ex_reg;               // Execute to result

    rv_decoder u_decoder (
        .clk, .rst_n, .insn_valid, .insn, .pc,
        .rs1_data, .rs2_data, .ex_now, .ex_reg,
        .rs1_addr, .rs2_addr, .dec
    );

    alu_execute u_execute (
        .clk, .rst_n, .dec,
        .ex_now, .ex_reg
    );

    gpr_writeback u_writeback (
        .clk, .rst_n, .ex_reg,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .retire_valid, .retire_we, .retire_redirect, .retire_illegal,
        .retire_rd, .retire_data, .retire_target
    );

endmodule

//--- tb/rv_encode.svh
// Instruction word builders for the mini core tests
// R, I, U, B and J formats plus immediate sign extension

`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

////////////////////////////////////////
// Formats
////////////////////////////////////////
function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3,
                                input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};  // Also used for shift immediates
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd,
                                input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                input logic [6:0] op);
    return {imm, rd, op};
endfunction

// Branch offset bit 0 is implied zero
function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

// Sign extension of the raw immediates
function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic word_t sext13(input logic [12:0] v);
    return {{19{v[12]}}, v};
endfunction

function automatic word_t sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
endfunction

`endif

//--- tb/tb_mini_core.sv
// Testbench for the mini core
// Directed tests against a reference register model, each retire
// checked exactly three cycles after its issue slot

`timescale 1ns/1ps

module tb_mini_core import core_pkg::*; ();

    `include "rv_encode.svh"

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int pipe_depth   = 3;                         // Issue to retire
    localparam int num_issues   = 31 + 30 + 40 + 54 + 9 + 9;  // Per test, in order
    localparam int num_idle     = 8 * pipe_depth;            // Flush slots
    localparam int timeout_ns   = (num_issues + num_idle + reset_cycles) * clk_period + 400;

    // Expected retire plus which payload fields matter
    typedef struct packed {
        ex_result_t r;
        logic       chk_data;
        logic       chk_target;
    } exp_t;

    logic      clk, rst_n, insn_valid;
    word_t     insn, pc;
    logic      retire_valid, retire_we, retire_redirect, retire_illegal;
    reg_addr_t retire_rd;
    word_t     retire_data, retire_target;

    word_t       model_regs [num_regs];   // Reference register file
    exp_t        pipe [pipe_depth];       // Expected retires in flight
    word_t       cur_pc;
    logic [31:0] rng_state;
    int          errors, checks;

    mini_core DUT (
        .clk, .rst_n, .insn_valid, .insn, .pc,
        .retire_valid, .retire_rd, .retire_we, .retire_data,
        .retire_redirect, .retire_target, .retire_illegal
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);   // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_addr_t rand_reg();    // Never x0
        logic [31:0] r;
        r = next_rand();
        return reg_addr_t'(r % 31 + 1);
    endfunction

    // Signed less than from the sign bits
    function automatic logic signed_lt(input word_t a, input word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            f3_add:  return alt ? a - b : a + b;
            f3_sll:  return a << b[4:0];
            f3_slt:  return {31'b0, signed_lt(a, b)};
            f3_sltu: return {31'b0, a < b};
            f3_xor:  return a ^ b;
            f3_sr:   return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : '0);
            f3_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return signed_lt(a, b);
            f3_bge:  return !signed_lt(a, b);
            f3_bltu: return a < b;
            default: return !(a < b);   // BGEU
        endcase
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_retire(input exp_t e);
        check_bit("retire_valid", retire_valid, e.r.valid);
        if (e.r.valid) begin
            check_bit("retire_we", retire_we, e.r.we);
            check_bit("retire_redirect", retire_redirect, e.r.redirect);
            check_bit("retire_illegal", retire_illegal, e.r.illegal);
            if (e.chk_data) begin
                check_addr("retire_rd", retire_rd, e.r.rd);
                check_word("retire_data", retire_data, e.r.data);
            end
            if (e.chk_target)
                check_word("retire_target", retire_target, e.r.target);
        end
    endtask

    ////////////////////////////////////////
    // Issue helpers
    ////////////////////////////////////////
    // One slot: check the oldest entry, then drive on the falling edge
    task automatic step_cycle(input logic v, input word_t w, input exp_t e);
        @(negedge clk);
        check_retire(pipe[2]);
        pipe[2]    = pipe[1];
        pipe[1]    = pipe[0];
        pipe[0]    = e;
        insn_valid = v;
        insn       = w;
        pc         = cur_pc;
        if (v)
            cur_pc = cur_pc + 32'd4;
    endtask

    task automatic flush_pipe();
        repeat (pipe_depth) step_cycle(1'b0, '0, '0);
    endtask

    task automatic retire_write(input reg_addr_t rd, input word_t data, input word_t w);
        exp_t e;
        e            = '0;
        e.r.valid    = 1'b1;
        e.r.rd       = rd;
        e.r.we       = (rd != 0);   // x0 writes dropped
        e.r.data     = data;
        e.chk_data   = 1'b1;
        if (rd != 0)
            model_regs[rd] = data;
        step_cycle(1'b1, w, e);
    endtask

    task automatic retire_jump(input reg_addr_t rd, input word_t target, input word_t w);
        exp_t e;
        e            = '0;
        e.r.valid    = 1'b1;
        e.r.rd       = rd;
        e.r.we       = (rd != 0);
        e.r.data     = cur_pc + 32'd4;   // Link
        e.r.redirect = 1'b1;
        e.r.target   = target;
        e.chk_data   = 1'b1;
        e.chk_target = 1'b1;
        if (rd != 0)
            model_regs[rd] = cur_pc + 32'd4;
        step_cycle(1'b1, w, e);
    endtask

    task automatic issue_alui(input logic [2:0] f3, input reg_addr_t rd,
                              input reg_addr_t rs1, input logic [11:0] imm);
        retire_write(rd, alu_ref(f3, 1'b0, model_regs[rs1], sext12(imm)),
                     enc_i(imm, rs1, f3, rd, op_alsi));
    endtask

    task automatic issue_shifti(input logic alt, input logic [2:0] f3, input reg_addr_t rd,
                                input reg_addr_t rs1, input logic [4:0] shamt);
        retire_write(rd, alu_ref(f3, alt, model_regs[rs1], {27'b0, shamt}),
                     enc_r(alt ? funct7_alt : funct7_base, shamt, rs1, f3, rd, op_alsi));
    endtask

    task automatic issue_alu(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                             input reg_addr_t rs1, input reg_addr_t rs2);
        retire_write(rd, alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]),
                     enc_r(alt ? funct7_alt : funct7_base, rs2, rs1, f3, rd, op_als));
    endtask

    task automatic issue_branch(input logic [2:0] f3, input reg_addr_t rs1,
                                input reg_addr_t rs2, input logic [12:0] imm);
        exp_t e;
        e            = '0;
        e.r.valid    = 1'b1;
        e.r.redirect = br_ref(f3, model_regs[rs1], model_regs[rs2]);
        e.r.target   = cur_pc + sext13(imm);
        e.chk_target = 1'b1;
        step_cycle(1'b1, enc_b(imm, rs2, rs1, f3), e);
    endtask

    task automatic issue_illegal(input word_t w);
        exp_t e;
        e           = '0;
        e.r.valid   = 1'b1;
        e.r.illegal = 1'b1;   // No write, no redirect
        step_cycle(1'b1, w, e);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_reset_zero();
        logic [31:0] r;
        int          i;
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("retire_we", retire_we, 1'b0);
        check_bit("retire_redirect", retire_redirect, 1'b0);
        check_bit("retire_illegal", retire_illegal, 1'b0);
        for (i = 1; i < num_regs; i++) begin
            r = next_rand();
            // Reads its own reset value, so data equals imm
            issue_alui(f3_add, reg_addr_t'(i), reg_addr_t'(i), r[11:0]);
        end
        flush_pipe();
    endtask

    task automatic test_imm_ops();
        logic [31:0] r;
        reg_addr_t   rd, rs1;
        int          n;
        for (n = 0; n < 30; n++) begin
            r   = next_rand();
            rd  = rand_reg();
            rs1 = rand_reg();
            case (n % 11)   // Every kind in turn
                0: issue_alui(f3_add, rd, rs1, r[11:0]);
                1: issue_alui(f3_slt, rd, rs1, r[11:0]);
                2: issue_alui(f3_sltu, rd, rs1, r[11:0]);
                3: issue_alui(f3_xor, rd, rs1, r[11:0]);
                4: issue_alui(f3_or, rd, rs1, r[11:0]);
                5: issue_alui(f3_and, rd, rs1, r[11:0]);
                6: issue_shifti(1'b0, f3_sll, rd, rs1, r[24:20]);
                7: issue_shifti(1'b0, f3_sr, rd, rs1, r[24:20]);
                8: issue_shifti(1'b1, f3_sr, rd, rs1, r[24:20]);
                9: retire_write(rd, {r[19:0], 12'b0}, enc_u(r[19:0], rd, op_lui));
                default: retire_write(rd, cur_pc + {r[19:0], 12'b0}, enc_u(r[19:0], rd, op_auipc));
            endcase
        end
        flush_pipe();
    endtask

    task automatic test_reg_forwarding();
        logic [2:0] f3;
        logic       alt;
        reg_addr_t  ra, rb, rc, rs, rt;
        int         k;
        for (k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? f3_add : f3_sr);   // Then SUB, SRA
            alt = (k >= 8);
            ra  = rand_reg();
            rb  = rand_reg();
            rc  = rand_reg();
            rs  = rand_reg();
            rt  = rand_reg();
            issue_alu(f3, alt, ra, rb, rc);
            issue_alu(f3, alt, ra, ra, rb);   // One slot back, rewrites ra
            issue_alu(f3, alt, rs, rc, ra);   // Two writers of ra in flight
            issue_alu(f3, alt, rt, ra, rs);   // Two slots and one slot
        end
        flush_pipe();
    endtask

    task automatic test_branches();
        logic [2:0]  f3;
        logic [11:0] va, vb;
        logic [31:0] r;
        int          i, j;
        for (i = 0; i < 6; i++) begin
            f3 = (i < 2) ? 3'(i) : 3'(i + 2);
            for (j = 0; j < 3; j++) begin
                // Equal, signed less, signed greater (unsigned order flips)
                va = (j == 0) ? 12'hffb : ((j == 1) ? 12'hff9 : 12'h009);
                vb = (j == 0) ? 12'hffb : ((j == 1) ? 12'h003 : 12'hffe);
                r  = next_rand();
                issue_alui(f3_add, 5'd5, 5'd0, va);
                issue_alui(f3_add, 5'd6, 5'd0, vb);
                issue_branch(f3, 5'd5, 5'd6, {r[12:1], 1'b0});
            end
        end
        flush_pipe();
    endtask

    task automatic test_jumps();
        logic [31:0] r;
        word_t       t;
        r      = next_rand();
        cur_pc = {r[31:12], 12'h000};
        issue_alui(f3_add, 5'd5, 5'd0, {r[11:1], 1'b1});   // Nonzero x5
        issue_alui(f3_add, 5'd7, 5'd0, 12'h123);           // Odd JALR base
        r = next_rand();
        retire_jump(5'd1, cur_pc + sext21({r[20:1], 1'b0}), enc_j({r[20:1], 1'b0}, 5'd1));
        r = next_rand();
        t = model_regs[7] + sext12(r[11:0]);
        retire_jump(5'd2, {t[31:1], 1'b0}, enc_i(r[11:0], 5'd7, f3_add, 5'd2, op_jalr));
        t = model_regs[1] + sext12(12'hffd);               // Odd sum
        retire_jump(5'd3, {t[31:1], 1'b0}, enc_i(12'hffd, 5'd1, f3_add, 5'd3, op_jalr));
        retire_jump(5'd0, cur_pc + 32'd16, enc_j(21'd16, 5'd0));
        issue_alui(f3_add, 5'd0, 5'd5, 12'd77);            // Write to x0 dropped
        issue_alu(f3_add, 1'b0, 5'd9, 5'd0, 5'd5);         // No forward from x0
        flush_pipe();
        issue_alu(f3_add, 1'b0, 5'd10, 5'd0, 5'd0);
        flush_pipe();
    endtask

    task automatic test_illegal();
        issue_alui(f3_add, 5'd10, 5'd0, 12'h05a);
        issue_illegal(enc_i(12'h004, 5'd10, 3'b010, 5'd10, 7'b0000011));  // Load opcode
        issue_illegal(enc_i(12'h000, 5'd0, 3'b000, 5'd10, 7'b1111111));
        issue_illegal(enc_r(7'b0000001, 5'd10, 5'd10, f3_add, 5'd10, op_als));
        issue_illegal(enc_r(7'b0010000, 5'd10, 5'd10, f3_sr, 5'd10, op_als));
        issue_illegal(enc_b(13'h010, 5'd0, 5'd0, 3'b010));
        issue_illegal(enc_b(13'h010, 5'd0, 5'd0, 3'b011));
        issue_alu(f3_add, 1'b0, 5'd11, 5'd10, 5'd0);       // x10 untouched
        flush_pipe();
        issue_alui(f3_add, 5'd12, 5'd10, 12'h000);
        flush_pipe();
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        rst_n      = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        pc         = '0;
        rng_state  = 32'h16a37b29;
        cur_pc     = 32'h0000_1000;
        model_regs = '{default: '0};
        pipe       = '{default: '0};
        errors     = 0;
        checks     = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        test_reset_zero();
        test_imm_ops();
        test_reg_forwarding();
        test_branches();
        test_jumps();
        test_illegal();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns with tests still running", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
design/core_pkg.sv
design/rv_decoder.sv
design/alu_execute.sv
design/gpr_writeback.sv
design/mini_core.sv
tb/tb_mini_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mini core testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module tb_mini_core -f verilog.f \
    --Mdir "$obj_dir" -o sim_mini_core > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $build_log"
    exit 1
fi

"./$obj_dir/sim_mini_core" > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see $sim_log"
    exit 1
fi

if grep -qx "Testbench passed" "$sim_log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $sim_log"
    exit 1
fi
